// ==== flist.f ====
+incdir+.
axi_burst_pkg.sv
burst_addr_gen.sv
beat_ram.sv
axi_burst_ctrl.sv
axi_burst_slave.sv
tb_axi_burst_slave.sv

// ==== tb_axi_tasks.svh ====
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

logic [31:0] rng_state = 32'd95;
// Reference memory of 64 four-byte words folded onto the low address bits like the DUT
logic [7:0]  model_mem [256];

function automatic logic [31:0] rand_word();
  rng_state ^= rng_state << 13;
  rng_state ^= rng_state >> 17;
  rng_state ^= rng_state << 5;
  return rng_state;
endfunction

function automatic logic [11:0] rand_addr();
  return 12'((rand_word() % 1024) * 4);
endfunction

function automatic logic [31:0] model_word(input logic [11:0] addr);
  return {model_mem[{addr[7:2], 2'd3}], model_mem[{addr[7:2], 2'd2}],
          model_mem[{addr[7:2], 2'd1}], model_mem[{addr[7:2], 2'd0}]};
endfunction

// Next beat address by the AXI burst rules
function automatic logic [11:0] next_addr(input logic [11:0] addr, input axi_len_t len,
                                          input axi_burst_t burst);
  int a;
  int size;
  a = int'(addr) & ~3;
  size = (int'(len) + 1) * 4;
  if (burst == BURST_FIXED) begin
    return addr;
  end
  // Last beat of a WRAP block goes back to the block start
  if (burst == BURST_WRAP && (a % size) + 4 == size) begin
    return 12'(a - (a % size));
  end
  return 12'(a + 4);
endfunction

task automatic fill_burst(input axi_len_t len, input logic full);
  for (int b = 0; b <= len; b++) begin
    wdata_buf[b] = rand_word();
    wstrb_buf[b] = full ? 4'hf : 4'(rand_word());
  end
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
  assert (got === exp) else begin
    $display("ERR %s got %h exp %h", name, got, exp);
    test_errors++;
  end
endtask

// Keeps the current drive until AW (0), W (1) or AR (2) ready is seen
task automatic wait_ready(input int ch, input string name);
  int waited;
  waited = 0;
  #1;
  while (!(ch == 0 ? o_awready : ch == 1 ? o_wready : o_arready) && waited < HS_LIMIT) begin
    @(negedge S_AXI_ACLK);
    #1;
    waited++;
  end
  assert (waited < HS_LIMIT) else begin
    $display("No %s handshake within %0d cycles", name, HS_LIMIT);
    test_errors++;
  end
endtask

task automatic write_burst(input logic [11:0] addr, input axi_id_t id, input axi_len_t len,
                           input axi_burst_t burst, input int max_delay);
  logic [11:0] a;
  int d;
  a = addr;
  i_awaddr = addr;
  i_awid = id;
  i_awlen = len;
  i_awburst = burst;
  i_awvalid = 1'b1;
  wait_ready(0, "AW");
  // AWVALID high always blocks AR
  check_val("o_arready", o_arready, 1'b0);
  @(negedge S_AXI_ACLK);
  i_awvalid = 1'b0;
  for (int b = 0; b <= len; b++) begin
    i_wdata = wdata_buf[b];
    i_wstrb = wstrb_buf[b];
    i_wlast = (b == len);
    i_wvalid = 1'b1;
    wait_ready(1, "W");
    check_val("o_bvalid", o_bvalid, 1'b0);
    check_val("o_arready", o_arready, 1'b0);
    for (int i = 0; i < 4; i++) begin
      if (wstrb_buf[b][i]) begin
        model_mem[{a[7:2], 2'(i)}] = wdata_buf[b][i*8 +: 8];
      end
    end
    a = next_addr(a, len, burst);
    @(negedge S_AXI_ACLK);
  end
  i_wvalid = 1'b0;
  i_wlast = 1'b0;
  // First sample lands in the cycle right after the WLAST handshake
  d = int'(rand_word() % (max_delay + 1));
  for (int c = 0; c <= d; c++) begin
    i_bready = (c == d);
    #1;
    check_val("o_bvalid", o_bvalid, 1'b1);
    check_val("o_bid", o_bid, id);
    check_val("o_bresp", o_bresp, RESP_OKAY);
    // No read is taken before the B handshake
    check_val("o_arready", o_arready, 1'b0);
    @(negedge S_AXI_ACLK);
  end
  i_bready = 1'b0;
endtask

task automatic read_burst(input logic [11:0] addr, input axi_id_t id, input axi_len_t len,
                          input axi_burst_t burst, input int max_delay);
  logic [11:0] a;
  int d;
  a = addr;
  i_araddr = addr;
  i_arid = id;
  i_arlen = len;
  i_arburst = burst;
  i_arvalid = 1'b1;
  wait_ready(2, "AR");
  @(negedge S_AXI_ACLK);
  i_arvalid = 1'b0;
  for (int b = 0; b <= len; b++) begin
    d = int'(rand_word() % (max_delay + 1));
    // Every stalled cycle must show the same beat
    for (int c = 0; c <= d; c++) begin
      i_rready = (c == d);
      #1;
      check_val("o_rvalid", o_rvalid, 1'b1);
      check_val("o_rdata", o_rdata, model_word(a));
      check_val("o_rlast", o_rlast, b == len);
      check_val("o_rid", o_rid, id);
      check_val("o_rresp", o_rresp, RESP_OKAY);
      @(negedge S_AXI_ACLK);
    end
    a = next_addr(a, len, burst);
  end
  i_rready = 1'b0;
  check_val("o_rvalid", o_rvalid, 1'b0);
endtask

`endif

// ==== tb_axi_burst_slave.sv ====
`timescale 1ns/1ps

module tb_axi_burst_slave;

  import axi_burst_pkg::*;

  // About four times the summed beats plus worst-case ready delays
  localparam int CYCLE_LIMIT = 4000;
  localparam int HS_LIMIT    = 50;

  logic        S_AXI_ACLK;
  logic        S_AXI_ARESETN;
  logic [11:0] i_awaddr;
  logic [11:0] i_araddr;
  axi_id_t     i_awid;
  axi_id_t     i_arid;
  axi_id_t     o_bid;
  axi_id_t     o_rid;
  axi_len_t    i_awlen;
  axi_len_t    i_arlen;
  axi_burst_t  i_awburst;
  axi_burst_t  i_arburst;
  axi_resp_t   o_bresp;
  axi_resp_t   o_rresp;
  logic [31:0] i_wdata;
  logic [31:0] o_rdata;
  logic [3:0]  i_wstrb;
  logic        i_awvalid;
  logic        i_wvalid;
  logic        i_wlast;
  logic        i_bready;
  logic        i_arvalid;
  logic        i_rready;
  logic        o_awready;
  logic        o_wready;
  logic        o_bvalid;
  logic        o_arready;
  logic        o_rvalid;
  logic        o_rlast;

  int errors;
  int test_errors;
  int tests_failed;
  int test_num;
  int cycles;
  logic [31:0] wdata_buf [16];
  logic [3:0]  wstrb_buf [16];

  `include "tb_axi_tasks.svh"

  axi_burst_slave UUT (.*);

  initial begin
    S_AXI_ACLK = 1'b0;
    forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge S_AXI_ACLK);
      cycles++;
    end
    $display("Run stopped after %0d cycles, a transfer never completed", cycles);
    $display("TEST FAIL");
    $finish;
  end

  task automatic end_test(input string name);
    test_num++;
    errors += test_errors;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("Test %0d %s done, %0d errors", test_num, name, test_errors);
    test_errors = 0;
  endtask

  initial begin
    logic [11:0] addr;
    axi_id_t     id;
    axi_len_t    len;
    S_AXI_ARESETN = 1'b0;
    {i_awaddr, i_awid, i_awlen, i_awburst} = '0;
    {i_araddr, i_arid, i_arlen, i_arburst} = '0;
    {i_wdata, i_wstrb} = '0;
    {i_awvalid, i_wvalid, i_wlast, i_bready, i_arvalid, i_rready} = '0;
    {errors, test_errors, tests_failed, test_num} = '0;
    repeat (4) @(posedge S_AXI_ACLK);
    @(negedge S_AXI_ACLK);
    S_AXI_ARESETN = 1'b1;
    @(negedge S_AXI_ACLK);

    check_val("o_awready", o_awready, 1'b1);
    check_val("o_arready", o_arready, 1'b1);
    check_val("o_wready", o_wready, 1'b0);
    check_val("o_bvalid", o_bvalid, 1'b0);
    check_val("o_rvalid", o_rvalid, 1'b0);
    end_test("reset state");

    repeat (20) begin
      addr = rand_addr();
      id = axi_id_t'(rand_word());
      len = axi_len_t'(rand_word() % 16);
      fill_burst(len, 1'b1);
      write_burst(addr, id, len, BURST_INCR, 0);
      read_burst(addr, ~id, len, BURST_INCR, 0);
    end
    end_test("INCR round trip");

    // Full write first so partial strobes merge onto known bytes
    repeat (8) begin
      addr = rand_addr();
      id = axi_id_t'(rand_word());
      len = axi_len_t'(rand_word() % 4);
      fill_burst(len, 1'b1);
      write_burst(addr, id, len, BURST_INCR, 0);
      fill_burst(len, 1'b0);
      write_burst(addr, id, len, BURST_INCR, 0);
      read_burst(addr, id, len, BURST_INCR, 0);
    end
    end_test("strobes");

    for (int n = 2; n <= 16; n = n * 2) begin
      addr = 12'(((rand_word() % (64 / n)) * n + 1 + rand_word() % (n - 1)) * 4);
      id = axi_id_t'(rand_word());
      len = axi_len_t'(n - 1);
      fill_burst(len, 1'b1);
      write_burst(addr, id, len, BURST_WRAP, 0);
      read_burst(addr, id, len, BURST_WRAP, 0);
    end
    addr = rand_addr();
    fill_burst(0, 1'b1);
    write_burst(addr, id, 0, BURST_INCR, 0);
    fill_burst(3, 1'b0);
    write_burst(addr, id, 3, BURST_FIXED, 0);
    read_burst(addr, id, 3, BURST_FIXED, 0);
    end_test("WRAP and FIXED");

    repeat (8) begin
      addr = rand_addr();
      id = axi_id_t'(rand_word());
      len = axi_len_t'(rand_word() % 16);
      fill_burst(len, 1'b1);
      write_burst(addr, id, len, BURST_INCR, 5);
      read_burst(addr, axi_id_t'(rand_word()), len, BURST_INCR, 5);
    end
    end_test("back-pressure and IDs");

    // AR raised with AW and held until the write completes
    addr = rand_addr();
    id = axi_id_t'(rand_word());
    len = axi_len_t'(rand_word() % 8);
    fill_burst(len, 1'b1);
    i_araddr = addr;
    i_arid = ~id;
    i_arlen = len;
    i_arburst = BURST_INCR;
    i_arvalid = 1'b1;
    write_burst(addr, id, len, BURST_INCR, 2);
    read_burst(addr, ~id, len, BURST_INCR, 2);
    end_test("arbitration");

    $display("Tests run %0d, failed %0d, errors %0d", test_num, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== axi_burst_slave.sv ====
`timescale 1ns/1ps

module axi_burst_slave #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 12,
  parameter int MEM_AW = 6
) (
  input  logic                       S_AXI_ACLK,
  input  logic                       S_AXI_ARESETN,
  // AW
  input  logic [ADDR_W-1:0]          i_awaddr,
  input  axi_burst_pkg::axi_id_t     i_awid,
  input  axi_burst_pkg::axi_len_t    i_awlen,
  input  axi_burst_pkg::axi_burst_t  i_awburst,
  input  logic                       i_awvalid,
  output logic                       o_awready,
  // W
  input  logic [DATA_W-1:0]          i_wdata,
  input  logic [DATA_W/8-1:0]        i_wstrb,
  input  logic                       i_wlast,
  input  logic                       i_wvalid,
  output logic                       o_wready,
  // B
  output axi_burst_pkg::axi_id_t     o_bid,
  output axi_burst_pkg::axi_resp_t   o_bresp,
  output logic                       o_bvalid,
  input  logic                       i_bready,
  // AR
  input  logic [ADDR_W-1:0]          i_araddr,
  input  axi_burst_pkg::axi_id_t     i_arid,
  input  axi_burst_pkg::axi_len_t    i_arlen,
  input  axi_burst_pkg::axi_burst_t  i_arburst,
  input  logic                       i_arvalid,
  output logic                       o_arready,
  // R
  output logic [DATA_W-1:0]          o_rdata,
  output axi_burst_pkg::axi_id_t     o_rid,
  output axi_burst_pkg::axi_resp_t   o_rresp,
  output logic                       o_rlast,
  output logic                       o_rvalid,
  input  logic                       i_rready
);

  import axi_burst_pkg::*;

  burst_cmd_t aw_cmd;
  burst_cmd_t ar_cmd;

  logic              wr_load;
  logic              wr_step;
  logic              rd_load;
  logic              rd_step;
  logic              rd_last;
  logic [MEM_AW-1:0] wr_idx;
  logic [MEM_AW-1:0] rd_idx;

  assign aw_cmd = '{id: i_awid, len: i_awlen, burst: i_awburst};
  assign ar_cmd = '{id: i_arid, len: i_arlen, burst: i_arburst};

  axi_burst_ctrl u_ctrl (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_aw_cmd      (aw_cmd),
    .i_ar_cmd      (ar_cmd),
    .i_awvalid     (i_awvalid),
    .i_arvalid     (i_arvalid),
    .i_wvalid      (i_wvalid),
    .i_wlast       (i_wlast),
    .i_bready      (i_bready),
    .i_rready      (i_rready),
    .i_rd_last     (rd_last),
    .o_awready     (o_awready),
    .o_arready     (o_arready),
    .o_wready      (o_wready),
    .o_bvalid      (o_bvalid),
    .o_rvalid      (o_rvalid),
    .o_rlast       (o_rlast),
    .o_bid         (o_bid),
    .o_rid         (o_rid),
    .o_bresp       (o_bresp),
    .o_rresp       (o_rresp),
    .o_wr_load     (wr_load),
    .o_wr_step     (wr_step),
    .o_rd_load     (rd_load),
    .o_rd_step     (rd_step)
  );

  // Write side, burst end is taken from WLAST so o_last stays open
  burst_addr_gen #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W),
    .MEM_AW (MEM_AW)
  ) u_wr_addr (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_load        (wr_load),
    .i_step        (wr_step),
    .i_start_addr  (i_awaddr),
    .i_cmd         (aw_cmd),
    .o_word_idx    (wr_idx),
    .o_last        ()
  );

  burst_addr_gen #(
    .DATA_W (DATA_W),
    .ADDR_W (ADDR_W),
    .MEM_AW (MEM_AW)
  ) u_rd_addr (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .i_load        (rd_load),
    .i_step        (rd_step),
    .i_start_addr  (i_araddr),
    .i_cmd         (ar_cmd),
    .o_word_idx    (rd_idx),
    .o_last        (rd_last)
  );

  beat_ram #(
    .DATA_W (DATA_W),
    .MEM_AW (MEM_AW)
  ) u_ram (
    .S_AXI_ACLK (S_AXI_ACLK),
    .i_we       (wr_step),
    .i_waddr    (wr_idx),
    .i_raddr    (rd_idx),
    .i_wdata    (i_wdata),
    .i_wstrb    (i_wstrb),
    .o_rdata    (o_rdata)
  );

endmodule

// ==== axi_burst_ctrl.sv ====
`timescale 1ns/1ps

module axi_burst_ctrl (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  axi_burst_pkg::burst_cmd_t i_aw_cmd,
  input  axi_burst_pkg::burst_cmd_t i_ar_cmd,
  input  logic                      i_awvalid,
  input  logic                      i_arvalid,
  input  logic                      i_wvalid,
  input  logic                      i_wlast,
  input  logic                      i_bready,
  input  logic                      i_rready,
  input  logic                      i_rd_last,
  output logic                      o_awready,
  output logic                      o_arready,
  output logic                      o_wready,
  output logic                      o_bvalid,
  output logic                      o_rvalid,
  output logic                      o_rlast,
  output axi_burst_pkg::axi_id_t    o_bid,
  output axi_burst_pkg::axi_id_t    o_rid,
  output axi_burst_pkg::axi_resp_t  o_bresp,
  output axi_burst_pkg::axi_resp_t  o_rresp,
  output logic                      o_wr_load,
  output logic                      o_wr_step,
  output logic                      o_rd_load,
  output logic                      o_rd_step
);

  import axi_burst_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  axi_id_t bid_q;
  axi_id_t rid_q;

  // Channel readies and valids decode straight from the state
  assign o_awready = (state_q == ST_IDLE);
  // Write has priority and AR waits while AWVALID is up
  assign o_arready = (state_q == ST_IDLE) && !i_awvalid;
  assign o_wready  = (state_q == ST_WR_DATA);
  assign o_bvalid  = (state_q == ST_WR_RESP);
  assign o_rvalid  = (state_q == ST_RD_DATA);
  assign o_rlast   = o_rvalid && i_rd_last;

  // Handshakes drive the address generators
  assign o_wr_load = i_awvalid && o_awready;
  assign o_rd_load = i_arvalid && o_arready;
  assign o_wr_step = i_wvalid && o_wready;
  assign o_rd_step = o_rvalid && i_rready;

  assign o_bid   = bid_q;
  assign o_rid   = rid_q;
  assign o_bresp = RESP_OKAY;
  assign o_rresp = RESP_OKAY;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (o_wr_load) begin
          state_d = ST_WR_DATA;
        end else if (o_rd_load) begin
          state_d = ST_RD_DATA;
        end
      end
      ST_WR_DATA: begin
        // Burst end comes from the master's WLAST
        if (o_wr_step && i_wlast) begin
          state_d = ST_WR_RESP;
        end
      end
      ST_WR_RESP: begin
        if (i_bready) begin
          state_d = ST_IDLE;
        end
      end
      ST_RD_DATA: begin
        if (o_rd_step && i_rd_last) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state_q <= ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // IDs held for the response channels
  always_ff @(posedge S_AXI_ACLK) begin
    if (o_wr_load) begin
      bid_q <= i_aw_cmd.id;
    end
    if (o_rd_load) begin
      rid_q <= i_ar_cmd.id;
    end
  end

  a_one_addr_hs: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    !(o_wr_load && o_rd_load)
  ) else $error("AW and AR accepted in the same cycle");

  a_rlast_hold: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (o_rvalid && !i_rready) |=> (o_rvalid && $stable(o_rlast))
  ) else $error("RVALID or RLAST changed while R was stalled");

  a_bvalid_hold: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (o_bvalid && !i_bready) |=> o_bvalid
  ) else $error("BVALID dropped before BREADY");

endmodule

// ==== beat_ram.sv ====
`timescale 1ns/1ps

module beat_ram #(
  parameter int DATA_W = 32,
  parameter int MEM_AW = 6
) (
  input  logic                S_AXI_ACLK,
  input  logic                i_we,
  input  logic [MEM_AW-1:0]   i_waddr,
  input  logic [MEM_AW-1:0]   i_raddr,
  input  logic [DATA_W-1:0]   i_wdata,
  input  logic [DATA_W/8-1:0] i_wstrb,
  output logic [DATA_W-1:0]   o_rdata
);

  localparam int STRB_W = DATA_W / 8;
  localparam int DEPTH  = 2 ** MEM_AW;

  logic [DATA_W-1:0] mem [DEPTH];

  // Only strobed byte lanes are written
  always_ff @(posedge S_AXI_ACLK) begin
    if (i_we) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (i_wstrb[b]) begin
          mem[i_waddr][b*8 +: 8] <= i_wdata[b*8 +: 8];
        end
      end
    end
  end

  // Asynchronous read, follows the read index in the same cycle
  assign o_rdata = mem[i_raddr];

  a_waddr_known: assert property (
    @(posedge S_AXI_ACLK) i_we |-> !$isunknown(i_waddr)
  ) else $error("beat_ram write with unknown address");

endmodule

// ==== burst_addr_gen.sv ====
`timescale 1ns/1ps

module burst_addr_gen #(
  parameter int DATA_W = 32,
  parameter int ADDR_W = 12,
  parameter int MEM_AW = 6
) (
  input  logic                      S_AXI_ACLK,
  input  logic                      S_AXI_ARESETN,
  input  logic                      i_load,
  input  logic                      i_step,
  input  logic [ADDR_W-1:0]         i_start_addr,
  input  axi_burst_pkg::burst_cmd_t i_cmd,
  output logic [MEM_AW-1:0]         o_word_idx,
  output logic                      o_last
);

  import axi_burst_pkg::*;

  localparam int ADDR_LSB = $clog2(DATA_W / 8);
  localparam int BEAT_W   = ADDR_W - ADDR_LSB;

  logic [ADDR_W-1:0] addr_q;
  axi_burst_t        burst_q;
  axi_len_t          len_q;
  axi_len_t          beat_cnt_q;

  logic [BEAT_W-1:0] beat;
  logic [BEAT_W-1:0] beat_inc;
  logic [BEAT_W-1:0] wrap_mask;
  logic [BEAT_W-1:0] beat_wrap;
  logic [ADDR_W-1:0] addr_next;

  // Beat number of the current address
  assign beat     = addr_q[ADDR_W-1:ADDR_LSB];
  assign beat_inc = beat + 1'b1;

  // For WRAP the length is 2^n-1 and serves as the in-block mask
  assign wrap_mask = BEAT_W'(len_q);
  assign beat_wrap = (beat & ~wrap_mask) | (beat_inc & wrap_mask);

  always_comb begin
    case (burst_q)
      BURST_FIXED: addr_next = addr_q;
      BURST_WRAP:  addr_next = {beat_wrap, {ADDR_LSB{1'b0}}};
      // INCR and the reserved code
      default:     addr_next = {beat_inc, {ADDR_LSB{1'b0}}};
    endcase
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      addr_q     <= '0;
      burst_q    <= BURST_INCR;
      len_q      <= '0;
      beat_cnt_q <= '0;
    end else if (i_load) begin
      addr_q     <= i_start_addr;
      burst_q    <= i_cmd.burst;
      len_q      <= i_cmd.len;
      beat_cnt_q <= '0;
    end else if (i_step) begin
      addr_q     <= addr_next;
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  // Low beat bits index the memory, so addresses fold onto its size
  assign o_word_idx = beat[MEM_AW-1:0];
  assign o_last     = (beat_cnt_q == len_q);

  a_wrap_len: assert property (
    @(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
    (i_load && i_cmd.burst == BURST_WRAP) |->
      (i_cmd.len inside {8'd1, 8'd3, 8'd7, 8'd15})
  ) else $error("WRAP burst loaded with len %0d", i_cmd.len);

endmodule

// ==== axi_burst_pkg.sv ====
package axi_burst_pkg;

  // AXI field types with fixed widths
  typedef logic [7:0] axi_len_t;
  typedef logic [1:0] axi_burst_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [3:0] axi_id_t;

  // Burst type codes, reserved 2'b11 is handled as INCR
  localparam axi_burst_t BURST_FIXED = 2'b00;
  localparam axi_burst_t BURST_INCR  = 2'b01;
  localparam axi_burst_t BURST_WRAP  = 2'b10;

  localparam axi_resp_t RESP_OKAY = 2'b00;

  // One accepted AW or AR command
  typedef struct packed {
    axi_id_t    id;
    axi_len_t   len;
    axi_burst_t burst;
  } burst_cmd_t;

  // Transaction FSM states, one transfer in flight at a time
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_WR_DATA = 2'd1,
    ST_WR_RESP = 2'd2,
    ST_RD_DATA = 2'd3
  } ctrl_state_t;

endpackage
